// File: Bender.yml
package:
  name: mem_1r1w

sources:
  - include_dirs:
      - common
    files:
      - common/mem_pkg.sv
      - bank/pivot_bank.sv
      - cache/cache_store.sv
      - rtl/access_sched.sv
      - rtl/read_merge.sv
      - rtl/mem_1r1w_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - test/tb_mem_1r1w.sv

// File: bank/pivot_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_settings.svh"

module pivot_bank (
  input  wire                     clk,
  input  wire mem_pkg::bank_req_t req,
  output mem_pkg::data_t          dout
);

  mem_pkg::data_t mem [0:`MEM_NUM_ROWS-1];
  mem_pkg::data_t rd_q1;
  mem_pkg::data_t rd_q2;

  // single port, so a request is either a read or a write
  always_ff @(posedge clk) begin
    if (req.en && req.we) begin
      mem[req.row] <= req.data;
    end
    if (req.en && !req.we) begin
      rd_q1 <= mem[req.row];
    end
    rd_q2 <= rd_q1;
  end

  assign dout = rd_q2;

endmodule

`default_nettype wire

// File: cache/cache_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_settings.svh"

module cache_store (
  input  wire                     clk,
  input  wire mem_pkg::store_wr_t wr,
  input  wire                     rd1_en,
  input  wire mem_pkg::row_t      rd1_row,
  output mem_pkg::store_rd_t      rd1,
  input  wire                     rd2_en,
  input  wire mem_pkg::row_t      rd2_row,
  output mem_pkg::store_rd_t      rd2
);

  mem_pkg::map_entry_t map_mem [0:`MEM_NUM_ROWS-1];
  mem_pkg::data_t      data_mem [0:`MEM_NUM_ROWS-1];
  mem_pkg::store_rd_t  rd1_q;
  mem_pkg::store_rd_t  rd2_q;

  // map and cached word move together
  always_ff @(posedge clk) begin
    if (wr.en) begin
      map_mem[wr.row]  <= wr.map;
      data_mem[wr.row] <= wr.data;
    end
  end

  // port 1 serves the write pipeline, port 2 the reads
  always_ff @(posedge clk) begin
    if (rd1_en) begin
      rd1_q.map  <= map_mem[rd1_row];
      rd1_q.data <= data_mem[rd1_row];
    end
    if (rd2_en) begin
      rd2_q.map  <= map_mem[rd2_row];
      rd2_q.data <= data_mem[rd2_row];
    end
    rd1 <= rd1_q;
    rd2 <= rd2_q;
  end

endmodule

`default_nettype wire

// File: common/mem_pkg.sv
`default_nettype none

`include "mem_settings.svh"

package mem_pkg;

  typedef logic [`MEM_WIDTH-1:0] data_t;
  typedef logic [`MEM_ADDR_BITS-1:0] addr_t;
  typedef logic [`MEM_BANK_BITS-1:0] bank_t;
  typedef logic [`MEM_ROW_BITS-1:0] row_t;

  // which bank's word the cache holds for a row
  typedef struct packed {
    logic  valid;
    bank_t bank;
  } map_entry_t;

  typedef struct packed {
    logic  en;
    logic  we;
    row_t  row;
    data_t data;
  } bank_req_t;

  typedef struct packed {
    logic       en;
    row_t       row;
    map_entry_t map;
    data_t      data;
  } store_wr_t;

  typedef struct packed {
    map_entry_t map;
    data_t      data;
  } store_rd_t;

  typedef struct packed {
    logic  valid;
    bank_t bank;
    row_t  row;
  } rd_req_t;

  typedef struct packed {
    logic  valid;
    bank_t bank;
    row_t  row;
    data_t data;
  } wr_req_t;

  typedef enum logic {
    SWEEP,
    RUN
  } sweep_state_t;

endpackage

`default_nettype wire

// File: common/mem_settings.svh
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// data word width
`define MEM_WIDTH 16

// pivot banks, addressed by the low address bits
`define MEM_NUM_BANKS 4
`define MEM_BANK_BITS 2

// rows per bank, also the depth of the map table and cache
`define MEM_NUM_ROWS 16
`define MEM_ROW_BITS 4

// virtual address, bank bits plus row bits
`define MEM_ADDR_BITS 6

// read latency of the banks and the cache store
`define MEM_DELAY 2

`endif

// File: rtl/access_sched.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_settings.svh"

module access_sched (
  input  wire                                     clk,
  input  wire                                     rstvld,
  input  wire                                     vwrite,
  input  wire mem_pkg::addr_t                     vwraddr,
  input  wire mem_pkg::data_t                     vdin,
  input  wire                                     vread,
  input  wire mem_pkg::addr_t                     vrdaddr,
  output logic                                    ready,
  output mem_pkg::bank_req_t [`MEM_NUM_BANKS-1:0] bank_req,
  output mem_pkg::store_wr_t                      store_wr,
  output logic                                    store_rd1_en,
  output mem_pkg::row_t                           store_rd1_row,
  output logic                                    store_rd2_en,
  output mem_pkg::row_t                           store_rd2_row,
  input  wire mem_pkg::store_rd_t                 store_rd1,
  output mem_pkg::rd_req_t                        rd_req,
  output mem_pkg::wr_req_t                        wr_fwd
);

  mem_pkg::bank_t       rd_bank;
  mem_pkg::row_t        rd_row;
  mem_pkg::bank_t       wr_bank;
  mem_pkg::row_t        wr_row;
  logic                 rd_acc;
  logic                 wr_acc;
  mem_pkg::sweep_state_t state;
  mem_pkg::row_t        sweep_row;
  mem_pkg::wr_req_t     w1;
  mem_pkg::wr_req_t     w2;
  logic                 ov1_vld;
  logic                 ov2_vld;
  mem_pkg::store_rd_t   ov1;
  mem_pkg::store_rd_t   ov2;
  mem_pkg::store_rd_t   old;
  logic                 conflict;
  logic                 new_to_pivot;
  logic                 old_to_pivot;
  logic                 old_to_clear;
  logic                 pw_en;
  mem_pkg::bank_t       pw_bank;
  mem_pkg::data_t       pw_data;

  // bank in the low bits, row above
  assign rd_bank = vrdaddr[`MEM_BANK_BITS-1:0];
  assign rd_row  = vrdaddr[`MEM_ADDR_BITS-1:`MEM_BANK_BITS];
  assign wr_bank = vwraddr[`MEM_BANK_BITS-1:0];
  assign wr_row  = vwraddr[`MEM_ADDR_BITS-1:`MEM_BANK_BITS];

  assign ready  = (state == mem_pkg::RUN);
  assign rd_acc = vread && ready;
  assign wr_acc = vwrite && ready;

  // clear the map table one row per cycle
  always_ff @(posedge clk) begin
    if (rstvld) begin
      state     <= mem_pkg::SWEEP;
      sweep_row <= '0;
    end else if (state == mem_pkg::SWEEP) begin
      sweep_row <= sweep_row + 1'b1;
      if (sweep_row == mem_pkg::row_t'(`MEM_NUM_ROWS - 1)) begin
        state <= mem_pkg::RUN;
      end
    end
  end

  // write waits two cycles for its old map entry
  always_ff @(posedge clk) begin
    if (rstvld) begin
      w1.valid <= 1'b0;
      w2.valid <= 1'b0;
    end else begin
      w1.valid <= wr_acc;
      w2.valid <= w1.valid;
    end
    w1.bank <= wr_bank;
    w1.row  <= wr_row;
    w1.data <= vdin;
    w2.bank <= w1.bank;
    w2.row  <= w1.row;
    w2.data <= w1.data;
    ov1_vld <= store_wr.en && (store_wr.row == wr_row);
    ov1     <= '{map: store_wr.map, data: store_wr.data};
    if (store_wr.en && (store_wr.row == w1.row)) begin
      ov2_vld <= 1'b1;
      ov2     <= '{map: store_wr.map, data: store_wr.data};
    end else begin
      ov2_vld <= ov1_vld;
      ov2     <= ov1;
    end
  end

  assign old = ov2_vld ? ov2 : store_rd1;

  // placement at commit
  assign conflict     = w2.valid && rd_acc && (rd_bank == w2.bank);
  assign new_to_pivot = w2.valid && !conflict;
  assign old_to_pivot = conflict && old.map.valid && (old.map.bank != w2.bank);
  assign old_to_clear = new_to_pivot && old.map.valid && (old.map.bank == w2.bank);

  assign pw_en   = new_to_pivot || old_to_pivot;
  assign pw_bank = new_to_pivot ? w2.bank : old.map.bank;
  assign pw_data = new_to_pivot ? w2.data : old.data;

  always_comb begin
    store_wr = '0;
    if (state == mem_pkg::SWEEP) begin
      store_wr.en  = 1'b1;
      store_wr.row = sweep_row;
    end else if (conflict) begin
      store_wr.en        = 1'b1;
      store_wr.row       = w2.row;
      store_wr.map.valid = 1'b1;
      store_wr.map.bank  = w2.bank;
      store_wr.data      = w2.data;
    end else if (old_to_clear) begin
      store_wr.en  = 1'b1;
      store_wr.row = w2.row;
    end
  end

  // the read bank never takes a write in the same cycle
  always_comb begin
    for (int i = 0; i < `MEM_NUM_BANKS; i++) begin
      bank_req[i] = '0;
      if (rd_acc && (rd_bank == mem_pkg::bank_t'(i))) begin
        bank_req[i].en  = 1'b1;
        bank_req[i].row = rd_row;
      end else if (pw_en && (pw_bank == mem_pkg::bank_t'(i))) begin
        bank_req[i].en   = 1'b1;
        bank_req[i].we   = 1'b1;
        bank_req[i].row  = w2.row;
        bank_req[i].data = pw_data;
      end
    end
  end

  assign store_rd1_en  = wr_acc;
  assign store_rd1_row = wr_row;
  assign store_rd2_en  = rd_acc;
  assign store_rd2_row = rd_row;

  assign rd_req = '{valid: rd_acc, bank: rd_bank, row: rd_row};
  assign wr_fwd = w1;

endmodule

`default_nettype wire

// File: rtl/mem_1r1w_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_settings.svh"

module mem_1r1w_top (
  input  wire                 clk,
  input  wire                 rstvld,
  input  wire                 vwrite,
  input  wire mem_pkg::addr_t vwraddr,
  input  wire mem_pkg::data_t vdin,
  input  wire                 vread,
  input  wire mem_pkg::addr_t vrdaddr,
  output logic                vread_vld,
  output mem_pkg::data_t      vdout,
  output logic                vread_fwrd,
  output logic                ready
);

  mem_pkg::bank_req_t [`MEM_NUM_BANKS-1:0] bank_req;
  mem_pkg::data_t [`MEM_NUM_BANKS-1:0]     bank_dout;
  mem_pkg::store_wr_t                      store_wr;
  logic                                    store_rd1_en;
  mem_pkg::row_t                           store_rd1_row;
  logic                                    store_rd2_en;
  mem_pkg::row_t                           store_rd2_row;
  mem_pkg::store_rd_t                      store_rd1;
  mem_pkg::store_rd_t                      store_rd2;
  mem_pkg::rd_req_t                        rd_req;
  mem_pkg::wr_req_t                        wr_fwd;

  access_sched u_access_sched (
    .clk           (clk),
    .rstvld        (rstvld),
    .vwrite        (vwrite),
    .vwraddr       (vwraddr),
    .vdin          (vdin),
    .vread         (vread),
    .vrdaddr       (vrdaddr),
    .ready         (ready),
    .bank_req      (bank_req),
    .store_wr      (store_wr),
    .store_rd1_en  (store_rd1_en),
    .store_rd1_row (store_rd1_row),
    .store_rd2_en  (store_rd2_en),
    .store_rd2_row (store_rd2_row),
    .store_rd1     (store_rd1),
    .rd_req        (rd_req),
    .wr_fwd        (wr_fwd)
  );

  cache_store u_cache_store (
    .clk     (clk),
    .wr      (store_wr),
    .rd1_en  (store_rd1_en),
    .rd1_row (store_rd1_row),
    .rd1     (store_rd1),
    .rd2_en  (store_rd2_en),
    .rd2_row (store_rd2_row),
    .rd2     (store_rd2)
  );

  for (genvar b = 0; b < `MEM_NUM_BANKS; b++) begin : g_bank
    pivot_bank u_pivot_bank (
      .clk  (clk),
      .req  (bank_req[b]),
      .dout (bank_dout[b])
    );
  end

  read_merge u_read_merge (
    .clk        (clk),
    .rd_req     (rd_req),
    .wr_fwd     (wr_fwd),
    .bank_req   (bank_req),
    .store_wr   (store_wr),
    .store_rd2  (store_rd2),
    .bank_dout  (bank_dout),
    .vread_vld  (vread_vld),
    .vdout      (vdout),
    .vread_fwrd (vread_fwrd)
  );

endmodule

`default_nettype wire

// File: rtl/read_merge.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_settings.svh"

module read_merge (
  input  wire                                     clk,
  input  wire mem_pkg::rd_req_t                   rd_req,
  input  wire mem_pkg::wr_req_t                   wr_fwd,
  input  wire mem_pkg::bank_req_t [`MEM_NUM_BANKS-1:0] bank_req,
  input  wire mem_pkg::store_wr_t                 store_wr,
  input  wire mem_pkg::store_rd_t                 store_rd2,
  input  wire mem_pkg::data_t [`MEM_NUM_BANKS-1:0] bank_dout,
  output logic                                    vread_vld,
  output mem_pkg::data_t                          vdout,
  output logic                                    vread_fwrd
);

  mem_pkg::wr_req_t    wr_old;
  mem_pkg::rd_req_t    s1_rd;
  mem_pkg::rd_req_t    s2_rd;
  logic                s1_st_vld;
  logic                s2_st_vld;
  mem_pkg::store_rd_t  s1_st;
  mem_pkg::store_rd_t  s2_st;
  logic                s1_pv_vld;
  logic                s2_pv_vld;
  mem_pkg::data_t      s1_pv;
  mem_pkg::data_t      s2_pv;
  logic                s1_fw_vld;
  logic                s2_fw_vld;
  mem_pkg::data_t      s1_fw;
  mem_pkg::data_t      s2_fw;
  mem_pkg::map_entry_t map_out;
  mem_pkg::data_t      cache_out;
  mem_pkg::data_t      pivot_out;
  logic                in_cache;

  function automatic logic st_hit(mem_pkg::row_t row);
    return store_wr.en && (store_wr.row == row);
  endfunction

  function automatic logic pv_hit(mem_pkg::bank_t bank, mem_pkg::row_t row);
    return bank_req[bank].en && bank_req[bank].we && (bank_req[bank].row == row);
  endfunction

  function automatic logic fw_hit(mem_pkg::bank_t bank, mem_pkg::row_t row);
    return wr_old.valid && (wr_old.bank == bank) && (wr_old.row == row);
  endfunction

  // wr_old is the write accepted two cycles back, now committing
  always_ff @(posedge clk) begin
    wr_old <= wr_fwd;
  end

  // stage 1, first capture of in-flight commits
  always_ff @(posedge clk) begin
    s1_rd     <= rd_req;
    s1_st_vld <= st_hit(rd_req.row);
    s1_st     <= '{map: store_wr.map, data: store_wr.data};
    s1_pv_vld <= pv_hit(rd_req.bank, rd_req.row);
    s1_pv     <= bank_req[rd_req.bank].data;
    s1_fw_vld <= fw_hit(rd_req.bank, rd_req.row);
    s1_fw     <= wr_old.data;
  end

  // stage 2, newer commits win over stage 1
  always_ff @(posedge clk) begin
    s2_rd <= s1_rd;
    if (st_hit(s1_rd.row)) begin
      s2_st_vld <= 1'b1;
      s2_st     <= '{map: store_wr.map, data: store_wr.data};
    end else begin
      s2_st_vld <= s1_st_vld;
      s2_st     <= s1_st;
    end
    if (pv_hit(s1_rd.bank, s1_rd.row)) begin
      s2_pv_vld <= 1'b1;
      s2_pv     <= bank_req[s1_rd.bank].data;
    end else begin
      s2_pv_vld <= s1_pv_vld;
      s2_pv     <= s1_pv;
    end
    if (fw_hit(s1_rd.bank, s1_rd.row)) begin
      s2_fw_vld <= 1'b1;
      s2_fw     <= wr_old.data;
    end else begin
      s2_fw_vld <= s1_fw_vld;
      s2_fw     <= s1_fw;
    end
  end

  assign map_out   = s2_st_vld ? s2_st.map : store_rd2.map;
  assign cache_out = s2_st_vld ? s2_st.data : store_rd2.data;
  assign pivot_out = s2_pv_vld ? s2_pv : bank_dout[s2_rd.bank];
  assign in_cache  = map_out.valid && (map_out.bank == s2_rd.bank);

  // forwarded word, then cache, then pivot
  assign vread_vld  = s2_rd.valid;
  assign vdout      = s2_fw_vld ? s2_fw : (in_cache ? cache_out : pivot_out);
  assign vread_fwrd = s2_rd.valid && s2_fw_vld;

endmodule

`default_nettype wire

// File: tb.f
+incdir+common
common/mem_pkg.sv
bank/pivot_bank.sv
cache/cache_store.sv
rtl/access_sched.sv
rtl/read_merge.sv
rtl/mem_1r1w_top.sv
test/tb_mem_1r1w.sv

// File: test/tb_mem_1r1w.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_settings.svh"

module tb_mem_1r1w;

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 5;
  localparam int NUM_ADDR     = 1 << `MEM_ADDR_BITS;
  localparam int DRAIN        = 4;
  localparam int RAND_CYCLES  = 400;
  localparam int CONF_SEQS    = 16;
  localparam int CONF_LEN     = 6;
  localparam int FWD_TRIALS   = 45;
  localparam int RESET_BUDGET = RESET_CYCLES + `MEM_NUM_ROWS + 4;
  localparam int PLAN_CYCLES  = 2 * RESET_BUDGET + 3 * (NUM_ADDR + DRAIN)
                              + 2 * (RAND_CYCLES + DRAIN)
                              + CONF_SEQS * (`MEM_NUM_BANKS * CONF_LEN + 4)
                              + FWD_TRIALS * 6;

  logic           clk;
  logic           rstvld;
  logic           vwrite;
  mem_pkg::addr_t vwraddr;
  mem_pkg::data_t vdin;
  logic           vread;
  mem_pkg::addr_t vrdaddr;
  logic           vread_vld;
  mem_pkg::data_t vdout;
  logic           vread_fwrd;
  logic           ready;

  int             seed;
  int             cyc = 0;
  int             n_checks = 0;
  int             n_errors = 0;
  logic           mon_en = 1'b0;
  logic           ready_up = 1'b0;

  // reference model, one word and the cycle of its last write per address
  mem_pkg::data_t model_mem [0:NUM_ADDR-1];
  int             last_wr [0:NUM_ADDR-1];

  int             exp_due_q[$];
  mem_pkg::data_t exp_data_q[$];
  logic           exp_fwd_q[$];

  mem_1r1w_top u_mem_1r1w_top (
    .clk        (clk),
    .rstvld     (rstvld),
    .vwrite     (vwrite),
    .vwraddr    (vwraddr),
    .vdin       (vdin),
    .vread      (vread),
    .vrdaddr    (vrdaddr),
    .vread_vld  (vread_vld),
    .vdout      (vdout),
    .vread_fwrd (vread_fwrd),
    .ready      (ready)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  task automatic check_data(string name, mem_pkg::data_t exp, mem_pkg::data_t act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("FAIL time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("FAIL time=%0t signal=%s expected=%b actual=%b", $time, name, exp, act);
    end
  endtask

  function automatic mem_pkg::data_t fill_word(mem_pkg::addr_t a);
    return mem_pkg::data_t'({a, 4'h9, ~a});
  endfunction

  // outputs and inputs are both stable at the falling edge
  always @(negedge clk) begin : monitor
    int             due;
    mem_pkg::data_t exp_data;
    logic           exp_fwd;
    if (mon_en) begin
      if (exp_due_q.size() > 0 && exp_due_q[0] == cyc) begin
        due      = exp_due_q.pop_front();
        exp_data = exp_data_q.pop_front();
        exp_fwd  = exp_fwd_q.pop_front();
        check_bit("vread_vld", 1'b1, vread_vld);
        check_data("vdout", exp_data, vdout);
        check_bit("vread_fwrd", exp_fwd, vread_fwrd);
      end else begin
        check_bit("vread_vld", 1'b0, vread_vld);
      end
      if (ready_up && ready !== 1'b1) begin
        n_errors++;
        $display("ERROR: ready fell at %0t although no reset was applied", $time);
      end
      // read first, so a write in the same cycle is not seen
      if (ready === 1'b1 && vread === 1'b1) begin
        exp_due_q.push_back(cyc + `MEM_DELAY);
        exp_data_q.push_back(model_mem[vrdaddr]);
        exp_fwd_q.push_back((last_wr[vrdaddr] == cyc - 1) || (last_wr[vrdaddr] == cyc - 2));
      end
      if (ready === 1'b1 && vwrite === 1'b1) begin
        model_mem[vwraddr] = vdin;
        last_wr[vwraddr]   = cyc;
      end
    end
  end

  task automatic drive_idle();
    vwrite <= 1'b0;
    vread  <= 1'b0;
  endtask

  task automatic drive_random();
    vwrite  <= ($random(seed) % 2) != 0;
    vwraddr <= mem_pkg::addr_t'($random(seed));
    vdin    <= mem_pkg::data_t'($random(seed));
    vread   <= ($random(seed) % 2) != 0;
    vrdaddr <= mem_pkg::addr_t'($random(seed));
  endtask

  task automatic drain(int n);
    repeat (n) begin
      @(posedge clk);
      drive_idle();
    end
  endtask

  // strobes keep toggling through reset and the first half of the sweep
  task automatic run_reset();
    int waited;
    ready_up = 1'b0;
    @(posedge clk);
    rstvld <= 1'b1;
    drive_idle();
    repeat (RESET_CYCLES - 1) begin
      @(posedge clk);
      drive_random();
    end
    @(negedge clk);
    check_bit("ready", 1'b0, ready);
    check_bit("vread_vld", 1'b0, vread_vld);
    @(posedge clk);
    rstvld <= 1'b0;
    mon_en = 1'b1;
    drive_random();
    waited = 0;
    @(negedge clk);
    while (ready !== 1'b1 && waited < `MEM_NUM_ROWS + 2) begin
      waited++;
      @(posedge clk);
      if (waited < `MEM_NUM_ROWS / 2) begin
        drive_random();
      end else begin
        drive_idle();
      end
      @(negedge clk);
    end
    if (ready !== 1'b1) begin
      n_errors++;
      $display("ERROR: ready still low %0d cycles after reset was released", waited);
    end else begin
      ready_up = 1'b1;
    end
  endtask

  // writes only, so every word lands in its pivot bank
  task automatic write_all(bit use_fill);
    for (int a = 0; a < NUM_ADDR; a++) begin
      @(posedge clk);
      vread   <= 1'b0;
      vwrite  <= 1'b1;
      vwraddr <= mem_pkg::addr_t'(a);
      vdin    <= use_fill ? fill_word(mem_pkg::addr_t'(a)) : model_mem[a];
    end
    drain(DRAIN);
  endtask

  task automatic read_all();
    for (int a = 0; a < NUM_ADDR; a++) begin
      @(posedge clk);
      vwrite  <= 1'b0;
      vread   <= 1'b1;
      vrdaddr <= mem_pkg::addr_t'(a);
    end
    drain(DRAIN);
  endtask

  task automatic random_traffic();
    repeat (RAND_CYCLES) begin
      @(posedge clk);
      drive_random();
    end
    drain(DRAIN);
  endtask

  // read and write in one bank, one_row walks a single row over all banks
  task automatic conflict_burst(bit one_row);
    mem_pkg::bank_t b;
    mem_pkg::row_t  wr_row;
    mem_pkg::row_t  rd_row;
    int             n_banks;
    b       = mem_pkg::bank_t'($random(seed));
    wr_row  = mem_pkg::row_t'($random(seed));
    n_banks = one_row ? `MEM_NUM_BANKS : 1;
    for (int k = 0; k < n_banks; k++) begin
      repeat (CONF_LEN) begin
        @(posedge clk);
        if (!one_row) begin
          wr_row = mem_pkg::row_t'($random(seed));
        end
        rd_row = mem_pkg::row_t'($random(seed));
        if (rd_row == wr_row) begin
          rd_row = rd_row + 1'b1;
        end
        vwrite  <= 1'b1;
        vwraddr <= {wr_row, b};
        vdin    <= mem_pkg::data_t'($random(seed));
        vread   <= 1'b1;
        vrdaddr <= {rd_row, b};
      end
      b = b + 1'b1;
    end
    // lone write to the cached address, should clear the map entry
    @(posedge clk);
    vread   <= 1'b0;
    vwrite  <= 1'b1;
    vwraddr <= {wr_row, b - 1'b1};
    vdin    <= mem_pkg::data_t'($random(seed));
    drain(3);
  endtask

  task automatic forward_trial(int gap);
    mem_pkg::addr_t a;
    mem_pkg::data_t d;
    a = mem_pkg::addr_t'($random(seed));
    d = mem_pkg::data_t'($random(seed));
    for (int i = 0; i <= gap; i++) begin
      @(posedge clk);
      vwrite  <= (i == 0);
      vwraddr <= a;
      vdin    <= d;
      vread   <= (i == gap);
      vrdaddr <= a;
    end
    drain(3);
  endtask

  initial begin
    #(CLK_PERIOD * (PLAN_CYCLES + 100));
    $display("ERROR: timeout, the run did not finish within %0d cycles", PLAN_CYCLES + 100);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    seed    = 32'hdf5b;
    rstvld  = 1'b1;
    vwrite  = 1'b0;
    vwraddr = '0;
    vdin    = '0;
    vread   = 1'b0;
    vrdaddr = '0;
    for (int a = 0; a < NUM_ADDR; a++) begin
      model_mem[a] = 'x;
      last_wr[a]   = -100;
    end

    run_reset();
    write_all(1'b1);
    random_traffic();
    for (int s = 0; s < CONF_SEQS; s++) begin
      conflict_burst(s % 2 == 1);
    end
    for (int i = 0; i < FWD_TRIALS; i++) begin
      forward_trial(i % 3);
    end
    random_traffic();

    // pivot banks hold every word, so a second reset must not lose data
    write_all(1'b0);
    run_reset();
    read_all();

    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
